/* src.f */
+incdir+design
design/nocFlitPkg.sv
design/arbCtrlPkg.sv
design/arbLinks.sv
design/headerTracker.sv
design/holdTimerBank.sv
design/grantFsm.sv
design/switchArbiter.sv
test/arbChecker.sv
test/tb_switchArbiter.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the switch arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_switchArbiter --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* test/tb_switchArbiter.sv */
`include "arbiter_params.svh"

module tb_switchArbiter;
  timeunit 1ns;
  timeprecision 100ps;

  import nocFlitPkg::*;
  import arbCtrlPkg::*;

  localparam flitId_t headId = flitId_t'(`ARB_HEAD_ID);
  localparam flitId_t bodyId = flitId_t'(2);

  logic                     clk;
  logic                     rst;
  flitId_t [`ARB_PORTS-1:0] flitIds;
  pktLen_t [`ARB_PORTS-1:0] lengths;
  portMask_t                reqs;
  portMask_t                grant;
  int                       errors;
  int                       checks;
  int                       cycles = 0;
  int                       limit = 0;
  int                       seed = 32'h60d7_aa3a;

  // One entry per table row
  portMask_t                reqTab[$];
  portMask_t                headTab[$];
  pktLen_t [`ARB_PORTS-1:0] lenTab[$];
  int                       holdTab[$];
  bit                       rndTab[$];

  switchArbiter u_switchArbiter (
    .clk     (clk),
    .rst     (rst),
    .flitIds (flitIds),
    .lengths (lengths),
    .reqs    (reqs),
    .grant   (grant)
  );

  arbChecker u_arbChecker (
    .clk     (clk),
    .rst     (rst),
    .flitIds (flitIds),
    .lengths (lengths),
    .reqs    (reqs),
    .grant   (grant),
    .errors  (errors),
    .checks  (checks)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic addRow(input portMask_t req, input portMask_t head,
                        input pktLen_t [`ARB_PORTS-1:0] len, input int hold, input bit rnd);
    reqTab.push_back(req);
    headTab.push_back(head);
    lenTab.push_back(len);
    holdTab.push_back(hold);
    rndTab.push_back(rnd);
  endtask

  task automatic buildTable();
    pktLen_t [`ARB_PORTS-1:0] zeroLen;
    pktLen_t [`ARB_PORTS-1:0] eastLen;
    pktLen_t [`ARB_PORTS-1:0] localLen;
    zeroLen     = '0;
    eastLen     = '0;
    eastLen[2]  = 12'd3;
    localLen    = '0;
    localLen[0] = 12'd6;
    addRow(5'b00000, 5'b00000, zeroLen, 3, 1'b0);
    addRow(5'b00100, 5'b00000, zeroLen, 3, 1'b0);
    // East header of length 3, then North competes
    addRow(5'b00000, 5'b00100, eastLen, 2, 1'b0);
    addRow(5'b00100, 5'b00000, eastLen, 1, 1'b0);
    addRow(5'b00110, 5'b00000, eastLen, 8, 1'b0);
    // Clear every budget, then rotate through all ports
    addRow(5'b00000, 5'b11111, zeroLen, 2, 1'b0);
    addRow(5'b11111, 5'b00000, zeroLen, 12, 1'b0);
    // South owns and only West asks next
    addRow(5'b10000, 5'b00000, zeroLen, 2, 1'b0);
    addRow(5'b01000, 5'b00000, zeroLen, 3, 1'b0);
    // Local drops its request well before its budget of 6
    addRow(5'b00000, 5'b00001, localLen, 2, 1'b0);
    addRow(5'b00001, 5'b00000, localLen, 3, 1'b0);
    addRow(5'b00000, 5'b00000, localLen, 3, 1'b0);
    addRow(5'b00000, 5'b00000, zeroLen, 200, 1'b1);
  endtask

  task automatic driveCycle(input int row, input bit first);
    logic [31:0] r;
    @(negedge clk);
    if (rndTab[row])
    begin
      r    = $random(seed);
      reqs = r[4:0];
      for (int p = 0; p < `ARB_PORTS; p++)
      begin
        flitIds[p] = r[5+p] ? headId : bodyId;
        lengths[p] = pktLen_t'(r[10+3*p +: 3]);
      end
    end
    else
    begin
      reqs    = reqTab[row];
      lengths = lenTab[row];
      for (int p = 0; p < `ARB_PORTS; p++)
      begin
        flitIds[p] = (first && headTab[row][p]) ? headId : bodyId;
      end
    end
  endtask

  initial
  begin
    rst     = 1'b1;
    reqs    = '0;
    flitIds = '0;
    lengths = '0;
    buildTable();
    foreach (holdTab[i])
    begin
      limit += holdTab[i];
    end
    limit += 50;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int row = 0; row < holdTab.size(); row++)
    begin
      for (int c = 0; c < holdTab[row]; c++)
      begin
        driveCycle(row, c == 0);
      end
    end
    @(negedge clk);
    @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && checks > 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

endmodule

/* test/arbChecker.sv */
`include "arbiter_params.svh"

module arbChecker (
  input  logic                                 clk,
  input  logic                                 rst,
  input  nocFlitPkg::flitId_t [`ARB_PORTS-1:0] flitIds,
  input  nocFlitPkg::pktLen_t [`ARB_PORTS-1:0] lengths,
  input  arbCtrlPkg::portMask_t                reqs,
  input  arbCtrlPkg::portMask_t                grant,
  output int                                   errors,
  output int                                   checks
);
  timeunit 1ns;
  timeprecision 100ps;

  import nocFlitPkg::*;
  import arbCtrlPkg::*;

  pktLen_t budget [`ARB_PORTS];
  pktLen_t elapsed [`ARB_PORTS];
  int      owner = -1;
  bit      started = 1'b0;
  int      errCount = 0;
  int      checkCount = 0;

  function automatic portMask_t ownerMask(input int who);
    if (who < 0)
    begin
      return '0;
    end
    return portMask_t'(1 << who);
  endfunction

  // Reference model of the hold rule, stepped at every rising edge
  always @(posedge clk)
  begin
    int  next;
    int  cand;
    bit  keep;
    started = 1'b1;
    if (rst)
    begin
      owner = -1;
      for (int p = 0; p < `ARB_PORTS; p++)
      begin
        budget[p]  = '0;
        elapsed[p] = '0;
      end
    end
    else
    begin
      keep = (owner >= 0) && reqs[owner] && (elapsed[owner] != budget[owner]);
      next = keep ? owner : -1;
      // Circular search from the port after the owner, or from Local when idle
      for (int k = 1; k <= `ARB_PORTS && !keep; k++)
      begin
        cand = (owner < 0) ? k - 1 : (owner + k) % `ARB_PORTS;
        if (next < 0 && reqs[cand])
        begin
          next = cand;
        end
      end
      for (int p = 0; p < `ARB_PORTS; p++)
      begin
        elapsed[p] = (keep && p == owner) ? elapsed[p] + pktLen_t'(1) : '0;
        if (flitIds[p] == flitId_t'(`ARB_HEAD_ID))
        begin
          budget[p] = lengths[p];
        end
      end
      owner = next;
    end
  end

  // Grant is stable at the falling edge
  always @(negedge clk)
  begin
    if (started)
    begin
      checkCount++;
      if (grant !== ownerMask(owner))
      begin
        errCount++;
        $display("error at %0d ns: grant expected %b, got %b",
                 $time, ownerMask(owner), grant);
      end
    end
  end

  assign errors = errCount;
  assign checks = checkCount;

endmodule

/* design/switchArbiter.sv */
`include "arbiter_params.svh"

module switchArbiter (
  input  logic                                 clk,
  input  logic                                 rst,
  input  nocFlitPkg::flitId_t [`ARB_PORTS-1:0] flitIds,
  input  nocFlitPkg::pktLen_t [`ARB_PORTS-1:0] lengths,
  input  arbCtrlPkg::portMask_t                reqs,
  output arbCtrlPkg::portMask_t                grant
);

  arbLinks links ();

  // Budgets and request levels
  headerTracker u_headerTracker (
    .clk     (clk),
    .rst     (rst),
    .flitIds (flitIds),
    .lengths (lengths),
    .reqs    (reqs),
    .links   (links)
  );

  // Elapsed hold time per port
  holdTimerBank u_holdTimerBank (
    .clk   (clk),
    .rst   (rst),
    .links (links)
  );

  // Ownership and rotation
  grantFsm u_grantFsm (
    .clk   (clk),
    .rst   (rst),
    .links (links),
    .grant (grant)
  );

endmodule

/* design/grantFsm.sv */
`include "arbiter_params.svh"

module grantFsm (
  input  logic                  clk,
  input  logic                  rst,
  arbLinks.fsm                  links,
  output arbCtrlPkg::portMask_t grant
);
  import nocFlitPkg::*;
  import arbCtrlPkg::*;

  arbState_t state;
  arbState_t nextState;
  arbState_t candState;
  portMask_t expired;
  portIdx_t  ownerIdx;
  portIdx_t  searchStart;
  logic      owning;
  logic      keep;
  logic      anyReq;

  // Maps a port number to the state in which that port owns the output
  function automatic arbState_t ownState(input portIdx_t idx);
    arbState_t s;
    case (idx)
      portIdx_t'(0):
        s = OWN_L;
      portIdx_t'(1):
        s = OWN_N;
      portIdx_t'(2):
        s = OWN_E;
      portIdx_t'(3):
        s = OWN_W;
      portIdx_t'(4):
        s = OWN_S;
      default:
        s = IDLE;
    endcase
    return s;
  endfunction

  // A port has used up its hold time once elapsed reaches its budget
  always_comb
  begin
    for (int p = 0; p < `ARB_PORTS; p++)
    begin
      expired[p] = (links.elapsed[p] == links.budget[p]);
    end
  end

  // Decode the current owner; IDLE and any broken encoding own nothing
  always_comb
  begin
    owning   = 1'b1;
    ownerIdx = '0;
    case (state)
      OWN_L:
        ownerIdx = portIdx_t'(0);
      OWN_N:
        ownerIdx = portIdx_t'(1);
      OWN_E:
        ownerIdx = portIdx_t'(2);
      OWN_W:
        ownerIdx = portIdx_t'(3);
      OWN_S:
        ownerIdx = portIdx_t'(4);
      default:
        owning = 1'b0;
    endcase
  end

  // The owner keeps the output while it still requests and has time left
  assign keep = owning && links.req[ownerIdx] && !expired[ownerIdx];

  always_comb
  begin
    for (int p = 0; p < `ARB_PORTS; p++)
    begin
      links.run[p] = keep && (ownerIdx == portIdx_t'(p));
    end
  end

  // Search starts after the owner and wraps from South back to Local
  always_comb
  begin
    if (!owning)
    begin
      searchStart = '0;
    end
    else if (ownerIdx == portIdx_t'(`ARB_PORTS - 1))
    begin
      searchStart = '0;
    end
    else
    begin
      searchStart = ownerIdx + portIdx_t'(1);
    end
  end

  // First requesting port in circular order from searchStart.
  // Every port, West included, is tested on its own request
  always_comb
  begin
    int idx;
    idx       = 0;
    anyReq    = 1'b0;
    candState = IDLE;
    for (int k = 0; k < `ARB_PORTS; k++)
    begin
      idx = (int'(searchStart) + k) % `ARB_PORTS;
      if (!anyReq && links.req[idx])
      begin
        candState = ownState(portIdx_t'(idx));
        anyReq    = 1'b1;
      end
    end
  end

  always_comb
  begin
    if (keep)
    begin
      nextState = state;
    end
    else if (anyReq)
    begin
      nextState = candState;
    end
    else
    begin
      nextState = IDLE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  // Grant is the owner part of the one-hot state
  assign grant = state[`ARB_PORTS:1];

endmodule

/* design/holdTimerBank.sv */
`include "arbiter_params.svh"

module holdTimerBank (
  input  logic   clk,
  input  logic   rst,
  arbLinks.timers links
);
  import nocFlitPkg::*;

  pktLen_t [`ARB_PORTS-1:0] count;

  // A counter only runs while its port keeps the grant,
  // so a port always enters ownership with a count of zero
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else
    begin
      for (int p = 0; p < `ARB_PORTS; p++)
      begin
        if (links.run[p])
        begin
          count[p] <= count[p] + pktLen_t'(1);
        end
        else
        begin
          count[p] <= '0;
        end
      end
    end
  end

  assign links.elapsed = count;

endmodule

/* design/headerTracker.sv */
`include "arbiter_params.svh"

module headerTracker (
  input  logic                                 clk,
  input  logic                                 rst,
  input  nocFlitPkg::flitId_t [`ARB_PORTS-1:0] flitIds,
  input  nocFlitPkg::pktLen_t [`ARB_PORTS-1:0] lengths,
  input  arbCtrlPkg::portMask_t                reqs,
  arbLinks.tracker                             links
);
  import nocFlitPkg::*;

  pktLen_t [`ARB_PORTS-1:0] budgetQ;
  logic    [`ARB_PORTS-1:0] isHead;

  // A header flit starts a new packet on its port
  always_comb
  begin
    for (int p = 0; p < `ARB_PORTS; p++)
    begin
      isHead[p] = (flitIds[p] == flitId_t'(`ARB_HEAD_ID));
    end
  end

  // Each budget keeps the length of the last header seen on its port
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budgetQ <= '0;
    end
    else
    begin
      for (int p = 0; p < `ARB_PORTS; p++)
      begin
        if (isHead[p])
        begin
          budgetQ[p] <= lengths[p];
        end
      end
    end
  end

  assign links.budget = budgetQ;

  // Requests are plain levels and reach the FSM in the same cycle
  assign links.req = reqs;

endmodule

/* design/arbLinks.sv */
`include "arbiter_params.svh"

interface arbLinks;
  import nocFlitPkg::*;
  import arbCtrlPkg::*;

  // Request levels as seen by the FSM
  portMask_t req;

  // Hold budget per port, latched from the last header flit
  pktLen_t [`ARB_PORTS-1:0] budget;

  // Cycles the owner has spent holding the output
  pktLen_t [`ARB_PORTS-1:0] elapsed;

  // Counter enable, high only for an owner that keeps the grant
  portMask_t run;

  modport tracker (
    output req,
    output budget
  );

  modport timers (
    input  run,
    output elapsed
  );

  modport fsm (
    input  req,
    input  budget,
    input  elapsed,
    output run
  );

endinterface

/* design/arbCtrlPkg.sv */
`include "arbiter_params.svh"

package arbCtrlPkg;

  // One bit per port with bit 0 for Local
  typedef logic [`ARB_PORTS-1:0] portMask_t;

  // Bit 0 is IDLE and bits 1 to 5 follow the port order
  typedef enum logic [`ARB_STATE_W-1:0] {
    IDLE  = 6'b000001,
    OWN_L = 6'b000010,
    OWN_N = 6'b000100,
    OWN_E = 6'b001000,
    OWN_W = 6'b010000,
    OWN_S = 6'b100000
  } arbState_t;

endpackage

/* design/nocFlitPkg.sv */
`include "arbiter_params.svh"

package nocFlitPkg;

  // Flit id as presented on each input port
  typedef logic [`ARB_FLIT_ID_W-1:0] flitId_t;

  // Length from a header flit, reused as a hold budget in cycles
  typedef logic [`ARB_LEN_W-1:0] pktLen_t;

  // Port number from 0 to 4 in the order L, N, E, W, S
  typedef logic [`ARB_IDX_W-1:0] portIdx_t;

endpackage

/* design/arbiter_params.svh */
`ifndef ARBITER_PARAMS_SVH
`define ARBITER_PARAMS_SVH

// Router ports in rotation order L, N, E, W, S
`define ARB_PORTS 5

// Packet length and hold budget width in bits
`define ARB_LEN_W 12

// Flit id width and the width of a port number
`define ARB_FLIT_ID_W 3
`define ARB_IDX_W 3

// Grant state is one-hot with one extra bit for IDLE
`define ARB_STATE_W (`ARB_PORTS + 1)

// Flit id code that marks a header flit
`define ARB_HEAD_ID 1

`endif
